// File: spidergon_noc.f
logic/noc_pkg.sv
logic/flit_fifo.sv
logic/route_unit.sv
logic/port_arbiter.sv
logic/spidergon_node.sv
logic/spidergon_noc.sv
test/spidergon_noc_sva.sv
test/noc_checker.sv
test/spidergon_noc_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = spidergon_noc_tb
FILELIST = spidergon_noc.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail if the log reports failure"
	@echo "  clean  remove build output and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: test/noc_stim.txt
// test src kind dest payload exp_node
// kind 0 tail, 1 head, 2 body, 3 single; head and single payloads hold 10 bits
2 0 3 0 0a1 0
2 1 3 2 0b2 2
2 3 3 1 0c3 1
3 0 3 4 1e5 4
3 2 3 5 2f6 5
3 7 3 4 307 4
4 1 1 2 041 2
4 1 2 2 a411 2
4 1 0 2 a412 2
4 3 1 2 043 2
4 3 2 2 b431 2
4 3 0 2 b432 2
5 0 1 6 050 6
5 0 2 6 c501 6
5 0 0 6 c502 6
5 4 3 6 054 6
5 5 3 1 055 1
5 1 3 5 051 5
5 6 3 6 056 6
6 0 1 2 060 2
6 0 2 2 d601 2
6 0 2 2 d602 2
6 0 2 2 d603 2
6 0 2 2 d604 2
6 0 2 2 d605 2
6 0 0 2 d606 2
0 0 0 0 0 0

// File: test/spidergon_noc_tb.sv
// spidergon noc testbench
`timescale 1ns/1ns

module spidergon_noc_tb;
	localparam int NUM_NODES = 8;
	localparam int DATA_W = 16;
	localparam int FIFO_DEPTH = 2;
	localparam int NODE_W = $clog2(NUM_NODES);
	localparam int FLIT_W = noc_pkg::KIND_W + DATA_W;
	localparam int COLS = 6;
	localparam int LIMIT = 2000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [NUM_NODES-1:0] inject_valid = '0;
	logic [FLIT_W-1:0] inject_flit [NUM_NODES];
	logic [NUM_NODES-1:0] inject_full;
	logic [NUM_NODES-1:0] eject_valid;
	logic [FLIT_W-1:0] eject_flit [NUM_NODES];
	logic [NUM_NODES-1:0] eject_full = '0;
	logic [NODE_W-1:0] exp_node [NUM_NODES];
	int test_id = 0;
	logic test_done = 1'b0;
	int pending;
	int checks;
	int errors;
	logic [15:0] stim [64*COLS];
	logic [31:0] rng = 32'd22;

	always #4 clk = ~clk;

	spidergon_noc #(
		.NUM_NODES(NUM_NODES),
		.DATA_W(DATA_W),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_spidergon_noc (
		.clk(clk),
		.reset(reset),
		.inject_valid(inject_valid),
		.inject_flit(inject_flit),
		.inject_full(inject_full),
		.eject_valid(eject_valid),
		.eject_flit(eject_flit),
		.eject_full(eject_full)
	);

	noc_checker #(
		.NUM_NODES(NUM_NODES),
		.DATA_W(DATA_W)
	) u_checker (
		.clk(clk),
		.reset(reset),
		.inject_valid(inject_valid),
		.inject_flit(inject_flit),
		.inject_full(inject_full),
		.exp_node(exp_node),
		.eject_valid(eject_valid),
		.eject_flit(eject_flit),
		.eject_full(eject_full),
		.test_id(test_id),
		.test_done(test_done),
		.pending(pending),
		.checks(checks),
		.errors(errors)
	);

	bind spidergon_noc spidergon_noc_sva #(
		.NUM_NODES(NUM_NODES),
		.DATA_W(DATA_W)
	) u_sva (
		.clk(clk),
		.reset(reset),
		.eject_valid(eject_valid),
		.eject_flit(eject_flit)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// head and single carry destination and source above the payload
	function automatic logic [FLIT_W-1:0] make_flit(input int n);
		logic [15:0] src;
		logic [15:0] kind;
		logic [15:0] dest;
		logic [15:0] payload;
		src = stim[n*COLS+1];
		kind = stim[n*COLS+2];
		dest = stim[n*COLS+3];
		payload = stim[n*COLS+4];
		if (kind[0])
			return {kind[1:0], dest[NODE_W-1:0], src[NODE_W-1:0],
				payload[DATA_W-2*NODE_W-1:0]};
		return {kind[1:0], payload[DATA_W-1:0]};
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("test failed");
		$finish;
	endtask

	task automatic end_test();
		test_done = 1'b1;
		@(posedge clk);
		#1;
		test_done = 1'b0;
	endtask

	// all sources inject their flits of one test side by side
	task automatic run_test(input int id);
		int line_q [NUM_NODES][$];
		logic [NUM_NODES-1:0] took;
		int cycles;
		int left;
		int src;
		int dummy;
		test_id = id;
		for (int n = 0; stim[n*COLS] != '0; n++)
		begin
			src = int'(stim[n*COLS+1]);
			if (int'(stim[n*COLS]) == id)
				line_q[src].push_back(n);
		end
		// a blocked ejection lets the buffers fill up to the source
		if (id == 6)
			eject_full = '1;
		took = '0;
		cycles = 0;
		do
		begin
			left = 0;
			for (int s = 0; s < NUM_NODES; s++)
			begin
				if (took[s])
					dummy = line_q[s].pop_front();
				inject_valid[s] = (line_q[s].size() != 0);
				if (inject_valid[s])
				begin
					inject_flit[s] = make_flit(line_q[s][0]);
					exp_node[s] = stim[line_q[s][0]*COLS+5][NODE_W-1:0];
				end
				left += line_q[s].size();
			end
			if (id == 5)
			begin
				rng = xorshift(rng);
				eject_full = NUM_NODES'(rng & (rng >> 8));
			end
			if (id == 6 && inject_full != '0)
				eject_full = '0;
			if (left != 0)
			begin
				cycles++;
				if (cycles > LIMIT)
					stop_run($sformatf("timeout injecting the flits of test %0d", id));
				@(negedge clk);
				took = inject_valid & ~inject_full;
				@(posedge clk);
				#1;
			end
		end
		while (left != 0);
		if (id != 5)
			eject_full = '0;
		cycles = 0;
		while (pending != 0)
		begin
			cycles++;
			if (cycles > LIMIT)
				stop_run($sformatf("timeout, %0d flits of test %0d never ejected", pending, id));
			@(posedge clk);
			#1;
			if (id == 5)
			begin
				rng = xorshift(rng);
				eject_full = NUM_NODES'(rng & (rng >> 8));
			end
		end
		eject_full = '0;
		end_test();
	endtask

	initial
	begin
		for (int n = 0; n < NUM_NODES; n++)
		begin
			inject_flit[n] = '0;
			exp_node[n] = '0;
		end
		$readmemh("test/noc_stim.txt", stim);
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		test_id = 1;
		repeat (3) @(posedge clk);
		#1;
		end_test();
		for (int t = 2; t <= 6; t++)
			run_test(t);
		$display("tests 6, checks %0d, errors %0d, assertion failures %0d", checks, errors,
			u_spidergon_noc.u_sva.fail_count);
		if (errors == 0 && u_spidergon_noc.u_sva.fail_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: test/noc_checker.sv
// noc scoreboard
`timescale 1ns/1ns

module noc_checker #(
	parameter int NUM_NODES = 8,
	parameter int DATA_W = 16,
	localparam int NODE_W = $clog2(NUM_NODES),
	localparam int FLIT_W = noc_pkg::KIND_W + DATA_W
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_NODES-1:0] inject_valid,
	input  logic [FLIT_W-1:0]    inject_flit [NUM_NODES],
	input  logic [NUM_NODES-1:0] inject_full,
	input  logic [NODE_W-1:0]    exp_node [NUM_NODES],
	input  logic [NUM_NODES-1:0] eject_valid,
	input  logic [FLIT_W-1:0]    eject_flit [NUM_NODES],
	input  logic [NUM_NODES-1:0] eject_full,
	input  int                   test_id,
	input  logic                 test_done,
	output int                   pending,
	output int                   checks,
	output int                   errors
);
	// expected flits per source and ejection node, in injection order
	logic [FLIT_W-1:0] expect_q [NUM_NODES*NUM_NODES][$];
	// source of the packet now leaving each ejection port
	logic [NODE_W-1:0] cur_src [NUM_NODES];
	int test_errors = 0;
	logic full_seen = 1'b0;

	function automatic string test_name(input int id);
		case (id)
			1: return "reset state";
			2: return "local and ring singles";
			3: return "across singles";
			4: return "packet merge";
			5: return "random eject back-pressure";
			6: return "buffer fill";
			default: return "unknown";
		endcase
	endfunction

	// sampled mid-cycle, values match those at the next rising edge
	always @(negedge clk)
	begin
		logic [FLIT_W-1:0] want;
		logic [NODE_W-1:0] src;
		noc_pkg::flit_kind_e kind;
		int key;
		if (!reset)
		begin
			if (test_id == 1)
			begin
				checks++;
				if (eject_valid != '0 || inject_full != '0)
				begin
					$display("Error %s: expected eject_valid 0 inject_full 0, actual %h %h",
						test_name(test_id), eject_valid, inject_full);
					errors++;
					test_errors++;
				end
			end
			if (inject_full != '0)
				full_seen = 1'b1;
			for (int s = 0; s < NUM_NODES; s++)
			begin
				if (inject_valid[s] && !inject_full[s])
				begin
					expect_q[s * NUM_NODES + int'(exp_node[s])].push_back(inject_flit[s]);
					pending++;
				end
			end
			for (int e = 0; e < NUM_NODES; e++)
			begin
				if (eject_valid[e] && !eject_full[e])
				begin
					kind = noc_pkg::flit_kind_e'(eject_flit[e][FLIT_W-1 -: noc_pkg::KIND_W]);
					src = cur_src[e];
					if (kind == noc_pkg::HEAD || kind == noc_pkg::SINGLE)
						src = eject_flit[e][DATA_W-1-NODE_W -: NODE_W];
					cur_src[e] = src;
					key = int'(src) * NUM_NODES + e;
					checks++;
					if (expect_q[key].size() == 0)
					begin
						$display("%s: node %0d ejected flit %h that no source sent there",
							test_name(test_id), e, eject_flit[e]);
						errors++;
						test_errors++;
					end
					else
					begin
						want = expect_q[key].pop_front();
						pending--;
						if (want !== eject_flit[e])
						begin
							$display("Error %s: node %0d expected %h actual %h",
								test_name(test_id), e, want, eject_flit[e]);
							errors++;
							test_errors++;
						end
					end
				end
			end
			if (test_done)
			begin
				if (test_id == 6 && !full_seen)
				begin
					$display("%s: inject_full never rose while ejection was blocked",
						test_name(test_id));
					errors++;
					test_errors++;
				end
				$display("test %0d %s: %0d errors", test_id, test_name(test_id), test_errors);
				test_errors = 0;
				full_seen = 1'b0;
			end
		end
	end

endmodule

// File: test/spidergon_noc_sva.sv
// spidergon noc assertions
`timescale 1ns/1ns

module spidergon_noc_sva #(
	parameter int NUM_NODES = 8,
	parameter int DATA_W = 16,
	localparam int FLIT_W = noc_pkg::KIND_W + DATA_W
) (
	input logic                 clk,
	input logic                 reset,
	input logic [NUM_NODES-1:0] eject_valid,
	input logic [FLIT_W-1:0]    eject_flit [NUM_NODES]
);
	// number of assertion failures so far
	int fail_count = 0;

	// ejection stays quiet while reset is held
	no_eject_in_reset: assert property (@(posedge clk) reset |=> eject_valid == '0)
	else
	begin
		fail_count++;
		$error("eject_valid high during reset");
	end

	for (genvar n = 0; n < NUM_NODES; n++)
	begin : g_eject
		logic [noc_pkg::KIND_W-1:0] kind;
		logic open;

		assign kind = eject_flit[n][FLIT_W-1 -: noc_pkg::KIND_W];

		// high between an ejected head and its tail
		always_ff @(posedge clk)
		begin
			if (reset)
				open <= 1'b0;
			else if (eject_valid[n])
				open <= (kind == noc_pkg::HEAD) || (kind == noc_pkg::BODY);
		end

		// every two-bit code is a kind, so only an unknown value is illegal
		legal_kind: assert property (@(posedge clk) disable iff (reset)
			eject_valid[n] |-> !$isunknown(kind))
		else
		begin
			fail_count++;
			$error("illegal flit kind ejected at node %0d", n);
		end

		body_after_head: assert property (@(posedge clk) disable iff (reset)
			eject_valid[n] && (kind == noc_pkg::BODY || kind == noc_pkg::TAIL) |-> open)
		else
		begin
			fail_count++;
			$error("body or tail ejected at node %0d without an open packet", n);
		end
	end

endmodule

// File: logic/spidergon_noc.sv
// spidergon network top level
`timescale 1ns/1ns

module spidergon_noc #(
	parameter int NUM_NODES = 8,
	parameter int DATA_W = 16,
	parameter int FIFO_DEPTH = 2,
	localparam int FLIT_W = noc_pkg::KIND_W + DATA_W
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [NUM_NODES-1:0] inject_valid,
	input  logic [FLIT_W-1:0]    inject_flit [NUM_NODES],
	output logic [NUM_NODES-1:0] inject_full,
	output logic [NUM_NODES-1:0] eject_valid,
	output logic [FLIT_W-1:0]    eject_flit [NUM_NODES],
	input  logic [NUM_NODES-1:0] eject_full
);
	// per node, per port link signals as seen from the node
	wire [noc_pkg::NUM_PORTS-1:0] link_in_valid [NUM_NODES];
	wire [FLIT_W-1:0] link_in_flit [NUM_NODES][noc_pkg::NUM_PORTS];
	wire [noc_pkg::NUM_PORTS-1:0] link_in_full [NUM_NODES];
	wire [noc_pkg::NUM_PORTS-1:0] link_out_valid [NUM_NODES];
	wire [FLIT_W-1:0] link_out_flit [NUM_NODES][noc_pkg::NUM_PORTS];
	wire [noc_pkg::NUM_PORTS-1:0] link_out_full [NUM_NODES];

	for (genvar n = 0; n < NUM_NODES; n++)
	begin : g_node
		localparam int PREV = (n + NUM_NODES - 1) % NUM_NODES;
		localparam int NEXT = (n + 1) % NUM_NODES;
		localparam int OPP = (n + NUM_NODES / 2) % NUM_NODES;

		// anticlockwise input comes from the clockwise output of the previous node
		assign link_in_valid[n][noc_pkg::ANTI] = link_out_valid[PREV][noc_pkg::CW];
		assign link_in_flit[n][noc_pkg::ANTI] = link_out_flit[PREV][noc_pkg::CW];
		assign link_out_full[n][noc_pkg::ANTI] = link_in_full[PREV][noc_pkg::CW];

		// clockwise input comes from the anticlockwise output of the next node
		assign link_in_valid[n][noc_pkg::CW] = link_out_valid[NEXT][noc_pkg::ANTI];
		assign link_in_flit[n][noc_pkg::CW] = link_out_flit[NEXT][noc_pkg::ANTI];
		assign link_out_full[n][noc_pkg::CW] = link_in_full[NEXT][noc_pkg::ANTI];

		// across link pairs node n with the node half a ring away
		assign link_in_valid[n][noc_pkg::ACROSS] = link_out_valid[OPP][noc_pkg::ACROSS];
		assign link_in_flit[n][noc_pkg::ACROSS] = link_out_flit[OPP][noc_pkg::ACROSS];
		assign link_out_full[n][noc_pkg::ACROSS] = link_in_full[OPP][noc_pkg::ACROSS];

		// local port is the inject and eject pair
		assign link_in_valid[n][noc_pkg::LOCAL] = inject_valid[n];
		assign link_in_flit[n][noc_pkg::LOCAL] = inject_flit[n];
		assign inject_full[n] = link_in_full[n][noc_pkg::LOCAL];
		assign eject_valid[n] = link_out_valid[n][noc_pkg::LOCAL];
		assign eject_flit[n] = link_out_flit[n][noc_pkg::LOCAL];
		assign link_out_full[n][noc_pkg::LOCAL] = eject_full[n];

		spidergon_node #(
			.NUM_NODES(NUM_NODES),
			.DATA_W(DATA_W),
			.FIFO_DEPTH(FIFO_DEPTH),
			.NODE_ID(n)
		) u_node (
			.clk(clk),
			.reset(reset),
			.in_valid(link_in_valid[n]),
			.in_flit(link_in_flit[n]),
			.in_full(link_in_full[n]),
			.out_valid(link_out_valid[n]),
			.out_flit(link_out_flit[n]),
			.out_full(link_out_full[n])
		);
	end

endmodule

// File: logic/spidergon_node.sv
// spidergon router node
`timescale 1ns/1ns

module spidergon_node #(
	parameter int NUM_NODES = 8,
	parameter int DATA_W = 16,
	parameter int FIFO_DEPTH = 2,
	parameter int NODE_ID = 0,
	localparam int FLIT_W = noc_pkg::KIND_W + DATA_W
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [noc_pkg::NUM_PORTS-1:0] in_valid,
	input  logic [FLIT_W-1:0]             in_flit [noc_pkg::NUM_PORTS],
	output logic [noc_pkg::NUM_PORTS-1:0] in_full,
	output logic [noc_pkg::NUM_PORTS-1:0] out_valid,
	output logic [FLIT_W-1:0]             out_flit [noc_pkg::NUM_PORTS],
	input  logic [noc_pkg::NUM_PORTS-1:0] out_full
);
	logic [FLIT_W-1:0] head_flit [noc_pkg::NUM_PORTS];
	logic [noc_pkg::NUM_PORTS-1:0] empty;
	logic [noc_pkg::NUM_PORTS-1:0] pop;
	noc_pkg::port_e route [noc_pkg::NUM_PORTS];
	noc_pkg::flit_kind_e head_kind [noc_pkg::NUM_PORTS];

	// indexed by output first, then by input
	logic [noc_pkg::NUM_PORTS-1:0] arb_req [noc_pkg::NUM_PORTS];
	logic [noc_pkg::NUM_PORTS-1:0] arb_grant [noc_pkg::NUM_PORTS];

	for (genvar p = 0; p < noc_pkg::NUM_PORTS; p++)
	begin : g_port
		// input side of port p
		flit_fifo #(
			.DATA_W(DATA_W),
			.FIFO_DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clk(clk),
			.reset(reset),
			.push(in_valid[p]),
			.push_flit(in_flit[p]),
			.pop(pop[p]),
			.head_flit(head_flit[p]),
			.empty(empty[p]),
			.full(in_full[p])
		);

		route_unit #(
			.NUM_NODES(NUM_NODES),
			.DATA_W(DATA_W),
			.NODE_ID(NODE_ID)
		) u_route (
			.clk(clk),
			.reset(reset),
			.head_flit(head_flit[p]),
			.head_valid(!empty[p]),
			.popped(pop[p]),
			.req_port(route[p])
		);

		assign head_kind[p] = noc_pkg::flit_kind_e'(head_flit[p][FLIT_W-1 -: noc_pkg::KIND_W]);

		// output side of port p
		port_arbiter u_arb (
			.clk(clk),
			.reset(reset),
			.req(arb_req[p]),
			.req_kind(head_kind),
			.out_full(out_full[p]),
			.grant(arb_grant[p])
		);
	end

	// each waiting head asks the arbiter of its routed output
	always_comb
	begin
		for (int o = 0; o < noc_pkg::NUM_PORTS; o++)
		begin
			for (int i = 0; i < noc_pkg::NUM_PORTS; i++)
				arb_req[o][i] = !empty[i] && (route[i] == o[noc_pkg::PORT_W-1:0]);
		end
	end

	// crossbar mux, a grant also pops the winning input
	always_comb
	begin
		pop = '0;
		for (int o = 0; o < noc_pkg::NUM_PORTS; o++)
		begin
			out_valid[o] = |arb_grant[o];
			out_flit[o] = '0;
			for (int i = 0; i < noc_pkg::NUM_PORTS; i++)
			begin
				if (arb_grant[o][i])
				begin
					out_flit[o] = head_flit[i];
					pop[i] = 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/port_arbiter.sv
// output port arbiter
`timescale 1ns/1ns

module port_arbiter (
	input  logic                          clk,
	input  logic                          reset,
	input  logic [noc_pkg::NUM_PORTS-1:0] req,
	input  noc_pkg::flit_kind_e           req_kind [noc_pkg::NUM_PORTS],
	input  logic                          out_full,
	output logic [noc_pkg::NUM_PORTS-1:0] grant
);
	noc_pkg::arb_state_e state;

	// last winner, doubles as the owner while locked
	logic [noc_pkg::PORT_W-1:0] last;
	logic [noc_pkg::PORT_W-1:0] cand;
	logic [noc_pkg::PORT_W-1:0] winner;
	logic found;

	always_comb
	begin
		grant = '0;
		winner = last;
		cand = last;
		found = 1'b0;
		if (state == noc_pkg::LOCKED)
		begin
			// only the owning input may continue its packet
			found = req[last];
		end
		else
		begin
			// round robin, starting just after the last winner
			for (int k = 1; k <= noc_pkg::NUM_PORTS; k++)
			begin
				cand = last + k[noc_pkg::PORT_W-1:0];
				if (!found && req[cand])
				begin
					found = 1'b1;
					winner = cand;
				end
			end
		end
		if (found && !out_full)
			grant[winner] = 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= noc_pkg::IDLE;
			last <= '0;
		end
		else if (|grant)
		begin
			last <= winner;
			case (req_kind[winner])
				noc_pkg::HEAD: state <= noc_pkg::LOCKED;
				noc_pkg::TAIL: state <= noc_pkg::IDLE;
				// single never locks, body keeps the lock
				default: state <= state;
			endcase
		end
	end

endmodule

// File: logic/route_unit.sv
// across-first route computation
`timescale 1ns/1ns

module route_unit #(
	parameter int NUM_NODES = 8,
	parameter int DATA_W = 16,
	parameter int NODE_ID = 0,
	localparam int NODE_W = $clog2(NUM_NODES),
	localparam int FLIT_W = noc_pkg::KIND_W + DATA_W
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [FLIT_W-1:0] head_flit,
	input  logic              head_valid,
	input  logic              popped,
	output noc_pkg::port_e    req_port
);
	localparam logic [NODE_W:0] OWN = (NODE_W + 1)'(NODE_ID);
	localparam logic [NODE_W:0] RING = (NODE_W + 1)'(NUM_NODES);
	localparam logic [NODE_W:0] QUARTER = (NODE_W + 1)'(NUM_NODES / 4);

	noc_pkg::flit_kind_e kind;
	logic [NODE_W-1:0] dest;
	logic [NODE_W:0] dest_ext;
	logic [NODE_W:0] rel;
	logic is_head;
	noc_pkg::port_e head_port;
	noc_pkg::port_e held_port;

	assign kind = noc_pkg::flit_kind_e'(head_flit[FLIT_W-1 -: noc_pkg::KIND_W]);

	// destination sits in the top bits of the data field
	assign dest = head_flit[DATA_W-1 -: NODE_W];
	assign dest_ext = {1'b0, dest};

	// clockwise distance to the destination, modulo the ring size
	assign rel = (dest_ext >= OWN) ? dest_ext - OWN : dest_ext + RING - OWN;

	assign is_head = (kind == noc_pkg::HEAD) || (kind == noc_pkg::SINGLE);

	// near nodes go around the ring, far ones take the across link first
	always_comb
	begin
		if (rel == '0)
			head_port = noc_pkg::LOCAL;
		else if (rel <= QUARTER)
			head_port = noc_pkg::CW;
		else if (rel >= RING - QUARTER)
			head_port = noc_pkg::ANTI;
		else
			head_port = noc_pkg::ACROSS;
	end

	// body and tail follow the path their head opened
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			held_port <= noc_pkg::LOCAL;
		end
		else if (popped && head_valid)
		begin
			if (kind == noc_pkg::HEAD)
				held_port <= head_port;
			else if (kind == noc_pkg::TAIL)
				held_port <= noc_pkg::LOCAL;
		end
	end

	assign req_port = is_head ? head_port : held_port;

endmodule

// File: logic/flit_fifo.sv
// input flit buffer
`timescale 1ns/1ns

module flit_fifo #(
	parameter int DATA_W = 16,
	parameter int FIFO_DEPTH = 2,
	localparam int FLIT_W = noc_pkg::KIND_W + DATA_W
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              push,
	input  logic [FLIT_W-1:0] push_flit,
	input  logic              pop,
	output logic [FLIT_W-1:0] head_flit,
	output logic              empty,
	output logic              full
);
	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic [FLIT_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// wrap at the depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// flags come from the registered count
	assign full = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	assign head_flit = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_flit;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: logic/noc_pkg.sv
// spidergon noc shared definitions

package noc_pkg;

	// width of the flit type field at the top of every flit
	localparam int KIND_W = 2;

	// anticlockwise, clockwise, across and local
	localparam int NUM_PORTS = 4;
	localparam int PORT_W = 2;

	// flit type, kept in the two msbs of a flit
	// single is a header with no body, so it opens and closes a packet
	typedef enum logic [KIND_W-1:0]
	{
		TAIL   = 2'b00,
		HEAD   = 2'b01,
		BODY   = 2'b10,
		SINGLE = 2'b11
	} flit_kind_e;

	// router port index, also used as the route of a packet
	typedef enum logic [PORT_W-1:0]
	{
		ANTI   = 2'd0,
		CW     = 2'd1,
		ACROSS = 2'd2,
		LOCAL  = 2'd3
	} port_e;

	// output arbiter state
	// locked while a multi-flit packet owns the output
	typedef enum logic
	{
		IDLE   = 1'b0,
		LOCKED = 1'b1
	} arb_state_e;

endpackage
